// ==== compile.f ====
+incdir+common
common/vis_pkg.sv
common/vis_word_if.sv
verilog/vis_bank_tracker.sv
prefetch/vis_prefetch_reader.sv
prefetch/vis_sram_writer.sv
verilog/vis_prefetch_top.sv
tests/tb_vis_prefetch.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# build and run the prefetch testbench with Verilator, verdict from the log
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert --timescale 1ns/1ns -f compile.f \
   --top-module tb_vis_prefetch -Mdir obj_dir -o sim_vis_prefetch \
   && ./obj_dir/sim_vis_prefetch 2>&1 | tee sim.log
grep -q "^All tests passed$" sim.log && echo "PASS" || { echo "FAIL"; exit 1; }

// ==== tests/tb_vis_prefetch.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "vis_defines.svh"

module tb_vis_prefetch;
   import vis_pkg::*;

   localparam int unsigned N_ROWS = 6;
   localparam int unsigned WORDS  = `VIS_COUNT * `VIS_BSIZE;   // 576 per prefetch

   logic      clk_i;
   logic      rst_i;
   logic      switch_i;
   logic      streamed_i;
   logic      ack_i;
   logic      rty_i;
   vis_word_t dat_i;
   logic      cyc_o;
   logic      stb_o;
   vis_adr_t  adr_o;
   logic      sram_ce_o;
   logic      sram_we_o;
   vis_adr_t  sram_ad_o;
   vis_word_t sram_di_o;
   vis_word_t checksum_o;
   logic      newblock_o;
   logic      overflow_o;

   // stimulus table with expected prefetch count and overflow per row
   int unsigned sw_tab     [N_ROWS] = '{1, 2, 3, 1, 15, 1};
   bit          stream_tab [N_ROWS] = '{1'b1, 1'b1, 1'b1, 1'b0, 1'b0, 1'b0};
   int unsigned fetch_tab  [N_ROWS] = '{1, 2, 3, 1, 0, 0};
   bit          ovf_tab    [N_ROWS] = '{1'b0, 1'b0, 1'b0, 1'b0, 1'b0, 1'b1};

   integer      seed;
   vis_word_t   sram_mem [0:1023];       // sram capture
   vis_word_t   exp_sum       = '0;      // xor of every acked word
   int unsigned wr_index      = 0;       // writes in the current prefetch
   int unsigned done_count    = 0;       // newblock pulses seen
   int unsigned stream_count  = 0;       // streamed pulses sent
   int unsigned fetch_goal    = 0;
   int unsigned cycle_count   = 0;
   int unsigned timeout_limit = 32'hffff_ffff;

   vis_prefetch_top u_vis_prefetch_top (
      .clk_i      (clk_i),
      .rst_i      (rst_i),
      .switch_i   (switch_i),
      .streamed_i (streamed_i),
      .overflow_o (overflow_o),
      .newblock_o (newblock_o),
      .checksum_o (checksum_o),
      .cyc_o      (cyc_o),
      .stb_o      (stb_o),
      .ack_i      (ack_i),
      .rty_i      (rty_i),
      .adr_o      (adr_o),
      .dat_i      (dat_i),
      .sram_ce_o  (sram_ce_o),
      .sram_we_o  (sram_we_o),
      .sram_ad_o  (sram_ad_o),
      .sram_di_o  (sram_di_o)
   );

   // ------------------------------------------------------------------------
   // reference model and run control
   // ------------------------------------------------------------------------
   // n-th address in block/word order with the block index on top
   function automatic vis_adr_t expected_addr(input int unsigned n);
      vis_blk_t b;
      vis_wrd_t w;
      b = vis_blk_t'(n / `VIS_BSIZE);
      w = vis_wrd_t'(n % `VIS_BSIZE);
      return {b, w};
   endfunction

   // word the correlator returns for an address in a given bank
   function automatic vis_word_t expected_word(input vis_adr_t a, input int unsigned serial);
      return (32'(a) * 32'h0000_9e37) ^ vis_word_t'(serial);
   endfunction

   task automatic finish_run(input bit passed);
      if (passed) begin
         $display("All tests passed");
         $finish;
      end else begin
         $display("Some tests failed");
         $fatal(1);
      end
   endtask

   task automatic fail_now(input string what);
      $display("%s", what);
      finish_run(1'b0);
   endtask

   task automatic wait_cycles(input int unsigned n);
      repeat (n) begin
         @(posedge clk_i);
         #10;
      end
   endtask

   initial begin
      clk_i = 1'b0;
      forever #50 clk_i = ~clk_i;   // 100 ns period
   end

   // watchdog
   always @(posedge clk_i) begin
      cycle_count++;
      if (cycle_count > timeout_limit)
         fail_now($sformatf("Timeout: run did not finish within %0d cycles", timeout_limit));
   end

   // ------------------------------------------------------------------------
   // correlator slave with random delay and one retry in eight
   // ------------------------------------------------------------------------
   initial begin : correlator_slave
      integer r;
      integer wait_n;
      seed  = 32'h80a1_e7f4;
      ack_i = 1'b0;
      rty_i = 1'b0;
      dat_i = '0;
      forever begin
         @(posedge clk_i);
         #10;
         if (stb_o) begin
            r      = $random(seed);
            wait_n = r & 3;                   // 0..3 cycles
            wait_cycles(wait_n);
            r = $random(seed);
            if ((r & 7) == 0) begin
               rty_i = 1'b1;
            end else begin
               ack_i   = 1'b1;
               dat_i   = expected_word(adr_o, done_count + 1);   // bank serial from 1
               exp_sum = exp_sum ^ dat_i;
            end
            @(posedge clk_i);
            #10;
            ack_i = 1'b0;
            rty_i = 1'b0;
            assert (!stb_o) else
               fail_now($sformatf("Mismatch at %0t: stb_o still high the cycle after a reply",
                                  $time));
         end
      end
   end

   // check write count, checksum and sram contents of a finished bank
   task automatic check_bank();
      int unsigned n;
      vis_adr_t    a;
      assert (wr_index == WORDS) else
         fail_now($sformatf("Mismatch at %0t: %0d sram writes, expected %0d",
                            $time, wr_index, WORDS));
      assert (checksum_o == exp_sum) else
         fail_now($sformatf("Mismatch at %0t: checksum %h, expected %h",
                            $time, checksum_o, exp_sum));
      for (n = 0; n < WORDS; n++) begin
         a = expected_addr(n);
         assert (sram_mem[a] == expected_word(a, done_count + 1)) else
            fail_now($sformatf("Mismatch at %0t: sram[%h] = %h, expected %h", $time, a,
                               sram_mem[a], expected_word(a, done_count + 1)));
      end
   endtask

   // sram capture and bus monitor at mid-cycle
   always @(negedge clk_i) begin
      assert (sram_ce_o == sram_we_o) else
         fail_now($sformatf("Mismatch at %0t: sram_ce_o %b, sram_we_o %b",
                            $time, sram_ce_o, sram_we_o));
      if (sram_we_o && sram_ce_o) begin
         assert (sram_ad_o == expected_addr(wr_index)) else
            fail_now($sformatf("Mismatch at %0t: sram address %h, expected %h",
                               $time, sram_ad_o, expected_addr(wr_index)));
         sram_mem[sram_ad_o] = sram_di_o;
         wr_index++;
      end
      if (newblock_o) begin
         check_bank();
         wr_index = 0;
         done_count++;
      end
      if (done_count > stream_count) begin   // no new fetch while the buffer is full
         assert (!cyc_o) else
            fail_now("Bus cycle started before the full buffer was streamed");
      end
   end

   // ------------------------------------------------------------------------
   // table-driven sequence
   // ------------------------------------------------------------------------
   task automatic run_row(input int unsigned r);
      int unsigned i;
      for (i = 0; i < sw_tab[r]; i++) begin
         switch_i = 1'b1;
         wait_cycles(1);
         switch_i = 1'b0;
         wait_cycles(1);
      end
      for (i = 0; i < fetch_tab[r]; i++) begin
         fetch_goal++;
         while (done_count < fetch_goal) begin
            wait_cycles(1);
         end
         if (stream_tab[r]) begin
            wait_cycles(4);                  // cyc_o watched meanwhile
            stream_count++;
            streamed_i = 1'b1;
            wait_cycles(1);
            streamed_i = 1'b0;
         end
      end
      wait_cycles(20);
      assert (done_count == fetch_goal) else
         fail_now($sformatf("Mismatch at %0t: row %0d, %0d newblock pulses, expected %0d",
                            $time, r, done_count, fetch_goal));
      assert (overflow_o == ovf_tab[r]) else
         fail_now($sformatf("Mismatch at %0t: row %0d, overflow %b, expected %b",
                            $time, r, overflow_o, ovf_tab[r]));
   endtask

   initial begin : main_seq
      int unsigned r;
      int unsigned banks;
      rst_i      = 1'b1;
      switch_i   = 1'b0;
      streamed_i = 1'b0;
      banks      = 0;
      for (r = 0; r < N_ROWS; r++) begin
         banks += fetch_tab[r];
      end
      timeout_limit = N_ROWS * banks * WORDS * 8 + 1000;
      wait_cycles(3);
      rst_i = 1'b0;
      for (r = 0; r < N_ROWS; r++) begin
         run_row(r);
      end
      wait_cycles(10);
      assert (overflow_o) else
         fail_now($sformatf("Mismatch at %0t: overflow dropped without reset", $time));
      rst_i = 1'b1;                          // overflow clears only here
      wait_cycles(3);
      rst_i = 1'b0;
      wait_cycles(1);
      assert (!overflow_o && !cyc_o && !newblock_o && checksum_o == '0) else
         fail_now($sformatf("Mismatch at %0t: state not cleared by reset", $time));
      finish_run(1'b1);
   end

endmodule

`default_nettype wire

// ==== verilog/vis_prefetch_top.sv ====
`timescale 1ns/1ns
`default_nettype none

module vis_prefetch_top (
   input  logic               clk_i,
   input  logic               rst_i,

   // correlator bank and spi status
   input  logic               switch_i,
   input  logic               streamed_i,
   output logic               overflow_o,
   output logic               newblock_o,
   output vis_pkg::vis_word_t checksum_o,

   // wishbone read master
   output logic               cyc_o,
   output logic               stb_o,
   input  logic               ack_i,
   input  logic               rty_i,
   output vis_pkg::vis_adr_t  adr_o,
   input  vis_pkg::vis_word_t dat_i,

   // external sram
   output logic               sram_ce_o,
   output logic               sram_we_o,
   output vis_pkg::vis_adr_t  sram_ad_o,
   output vis_pkg::vis_word_t sram_di_o
);

   logic start;   // tracker -> reader
   logic busy;    // reader -> tracker

   vis_word_if u_word_if ();   // reader -> writer

   // ---------------------------------------------------------------------------
   // tracker, reader, writer
   // ---------------------------------------------------------------------------
   vis_bank_tracker u_bank_tracker (
      .clk_i      (clk_i),
      .rst_i      (rst_i),
      .switch_i   (switch_i),
      .streamed_i (streamed_i),
      .busy_i     (busy),
      .start_o    (start),
      .overflow_o (overflow_o)
   );

   vis_prefetch_reader u_prefetch_reader (
      .clk_i   (clk_i),
      .rst_i   (rst_i),
      .start_i (start),
      .busy_o  (busy),
      .cyc_o   (cyc_o),
      .stb_o   (stb_o),
      .ack_i   (ack_i),
      .rty_i   (rty_i),
      .adr_o   (adr_o),
      .dat_i   (dat_i),
      .word_o  (u_word_if.producer)
   );

   vis_sram_writer u_sram_writer (
      .clk_i      (clk_i),
      .rst_i      (rst_i),
      .word_i     (u_word_if.consumer),
      .sram_ce_o  (sram_ce_o),
      .sram_we_o  (sram_we_o),
      .sram_ad_o  (sram_ad_o),
      .sram_di_o  (sram_di_o),
      .checksum_o (checksum_o),
      .newblock_o (newblock_o)
   );

endmodule

`default_nettype wire

// ==== prefetch/vis_sram_writer.sv ====
`timescale 1ns/1ns
`default_nettype none

module vis_sram_writer (
   input  logic               clk_i,
   input  logic               rst_i,
   vis_word_if.consumer       word_i,

   // external sram, all byte lanes on
   output logic               sram_ce_o,
   output logic               sram_we_o,
   output vis_pkg::vis_adr_t  sram_ad_o,
   output vis_pkg::vis_word_t sram_di_o,

   // status
   output vis_pkg::vis_word_t checksum_o,   // xor of every word since reset
   output logic               newblock_o    // prefetch complete
);
   import vis_pkg::*;

   logic      wr_q;      // sram strobe
   logic      last_q;    // this write ends the bank
   logic      done_q;
   vis_adr_t  ad_q;
   vis_word_t di_q;
   vis_word_t sum_q;

   // -------------------------------------------------------------------------
   // write strobe and completion
   // -------------------------------------------------------------------------
   always_ff @(posedge clk_i) begin
      if (rst_i) begin
         wr_q   <= 1'b0;
         last_q <= 1'b0;
         done_q <= 1'b0;
      end else begin
         wr_q   <= word_i.valid;
         last_q <= word_i.valid && word_i.last;
         done_q <= last_q;                   // one cycle past the last write
      end
   end

   // payload, follows the strobe
   always_ff @(posedge clk_i) begin
      if (word_i.valid) begin
         ad_q <= word_i.adr;
         di_q <= word_i.data;
      end
   end

   // running checksum
   always_ff @(posedge clk_i) begin
      if (rst_i) begin
         sum_q <= '0;
      end else if (word_i.valid) begin
         sum_q <= sum_q ^ word_i.data;
      end
   end

   assign sram_ce_o  = wr_q;
   assign sram_we_o  = wr_q;   // write-only port
   assign sram_ad_o  = ad_q;
   assign sram_di_o  = di_q;
   assign checksum_o = sum_q;
   assign newblock_o = done_q;

   a_done_after_write: assert property (@(posedge clk_i) disable iff (rst_i)
      newblock_o |-> $past(sram_we_o));

endmodule

`default_nettype wire

// ==== prefetch/vis_prefetch_reader.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "vis_defines.svh"

module vis_prefetch_reader (
   input  logic               clk_i,
   input  logic               rst_i,
   input  logic               start_i,   // one prefetch per pulse
   output logic               busy_o,

   // wishbone read master, correlator side
   output logic               cyc_o,
   output logic               stb_o,
   input  logic               ack_i,
   input  logic               rty_i,
   output vis_pkg::vis_adr_t  adr_o,
   input  vis_pkg::vis_word_t dat_i,

   // fetched words to the sram writer
   vis_word_if.producer       word_o
);
   import vis_pkg::*;

   // idle, request outstanding, one-cycle stb gap
   typedef enum logic [1:0] {
      RD_IDLE,
      RD_REQ,
      RD_GAP
   } rd_state_t;

   rd_state_t state_q;
   vis_blk_t  blk_q;     // correlator being read
   vis_wrd_t  wrd_q;     // word within the block
   logic      blk_end;
   logic      wrd_end;
   logic      final_wrd;
   logic      take;

   // -------------------------------------------------------------------------
   // address walk
   // -------------------------------------------------------------------------
   assign blk_end   = (blk_q == vis_blk_t'(`VIS_COUNT - 1));
   assign wrd_end   = (wrd_q == vis_wrd_t'(`VIS_BSIZE - 1));
   assign final_wrd = blk_end && wrd_end;
   assign take      = (state_q == RD_REQ) && ack_i;   // word accepted this cycle

   always_ff @(posedge clk_i) begin
      if (rst_i) begin
         state_q <= RD_IDLE;
         blk_q   <= '0;
         wrd_q   <= '0;
      end else begin
         case (state_q)
            RD_IDLE: begin
               if (start_i) begin
                  state_q <= RD_REQ;
                  blk_q   <= '0;
                  wrd_q   <= '0;
               end
            end
            RD_REQ: begin
               if (ack_i) begin
                  if (final_wrd) begin
                     state_q <= RD_IDLE;           // whole bank fetched
                  end else begin
                     state_q <= RD_GAP;
                     if (wrd_end) begin
                        wrd_q <= '0;
                        blk_q <= blk_q + vis_blk_t'(1);
                     end else begin
                        wrd_q <= wrd_q + vis_wrd_t'(1);
                     end
                  end
               end else if (rty_i) begin
                  state_q <= RD_GAP;               // same address again
               end
            end
            RD_GAP:  state_q <= RD_REQ;
            default: state_q <= RD_IDLE;
         endcase
      end
   end

   // -------------------------------------------------------------------------
   // bus and word outputs
   // -------------------------------------------------------------------------
   assign cyc_o  = (state_q != RD_IDLE);   // held across the gaps
   assign stb_o  = (state_q == RD_REQ);
   assign adr_o  = {blk_q, wrd_q};
   assign busy_o = start_i || (state_q != RD_IDLE);

   assign word_o.valid = take;             // never on rty
   assign word_o.adr   = {blk_q, wrd_q};
   assign word_o.data  = dat_i;
   assign word_o.last  = final_wrd;

   // slave must pick one answer
   a_one_reply: assert property (@(posedge clk_i) disable iff (rst_i)
      stb_o |-> !(ack_i && rty_i));

endmodule

`default_nettype wire

// ==== verilog/vis_bank_tracker.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "vis_defines.svh"

module vis_bank_tracker (
   input  logic clk_i,
   input  logic rst_i,
   input  logic switch_i,     // correlator finished a bank
   input  logic streamed_i,   // spi side has sent the buffer
   input  logic busy_i,       // reader still fetching
   output logic start_o,      // launch one prefetch
   output logic overflow_o    // too many banks waiting
);
   import vis_pkg::*;

   vis_qcnt_t count_q;   // pending banks
   logic      empty_q;   // output buffer free
   logic      start_q;
   logic      ovf_q;
   logic      full;
   logic      launch;
   logic      bump;

   // -------------------------------------------------------------------------
   // launch decision
   // -------------------------------------------------------------------------
   assign full   = (count_q == vis_qcnt_t'(`VIS_QDEPTH));
   assign launch = empty_q && !busy_i && (count_q != '0);   // empty_q drops with start
   assign bump   = switch_i && !full;                       // saturate when full

   // switch and launch on one edge leave the pending count alone
   always_ff @(posedge clk_i) begin
      if (rst_i) begin
         count_q <= '0;
      end else begin
         case ({bump, launch})
            2'b10:   count_q <= count_q + vis_qcnt_t'(1);
            2'b01:   count_q <= count_q - vis_qcnt_t'(1);
            default: count_q <= count_q;
         endcase
      end
   end

   // buffer state and start strobe
   always_ff @(posedge clk_i) begin
      if (rst_i) begin
         empty_q <= 1'b1;
         start_q <= 1'b0;
      end else begin
         start_q <= launch;
         if (launch) begin
            empty_q <= 1'b0;                 // buffer now being filled
         end else if (streamed_i) begin
            empty_q <= 1'b1;
         end
      end
   end

   // overflow latch cleared only by reset
   always_ff @(posedge clk_i) begin
      if (rst_i) begin
         ovf_q <= 1'b0;
      end else if (switch_i && full) begin
         ovf_q <= 1'b1;
      end
   end

   assign start_o    = start_q;
   assign overflow_o = ovf_q;

   // -------------------------------------------------------------------------
   // checks
   // -------------------------------------------------------------------------
   a_start_single: assert property (@(posedge clk_i) disable iff (rst_i)
      start_o |=> !start_o);

   // a switch into a full queue never wraps the count
   a_count_bound: assert property (@(posedge clk_i) disable iff (rst_i)
      full && switch_i |=> count_q >= vis_qcnt_t'(`VIS_QDEPTH - 1));

endmodule

`default_nettype wire

// ==== common/vis_word_if.sv ====
`timescale 1ns/1ns
`default_nettype none

// one fetched word, reader -> sram writer
interface vis_word_if;
   import vis_pkg::*;

   logic      valid;   // word present this cycle
   vis_adr_t  adr;     // where it came from, also where it goes
   vis_word_t data;
   logic      last;    // final word of the prefetch

   // reader side
   modport producer (
      output valid,
      output adr,
      output data,
      output last
   );

   // writer side
   modport consumer (
      input valid,
      input adr,
      input data,
      input last
   );

endinterface

`default_nettype wire

// ==== common/vis_pkg.sv ====
`default_nettype none

`include "vis_defines.svh"

package vis_pkg;

   // -------------------------------------------------------------------------
   // payload and index types
   // -------------------------------------------------------------------------

   // one visibility word off the correlator bus
   typedef logic [`VIS_WIDTH-1:0] vis_word_t;

   // block index, selects the correlator
   typedef logic [`VIS_CBITS-1:0] vis_blk_t;

   // word index within a block
   typedef logic [`VIS_BBITS-1:0] vis_wrd_t;

   // bus/sram address, block index in the upper bits
   typedef logic [`VIS_CBITS+`VIS_BBITS-1:0] vis_adr_t;

   // number of banks waiting to be fetched
   typedef logic [`VIS_QBITS-1:0] vis_qcnt_t;

endpackage

`default_nettype wire

// ==== common/vis_defines.svh ====
`ifndef VIS_DEFINES_SVH
`define VIS_DEFINES_SVH

// ---------------------------------------------------------------------------
// prefetch geometry
// ---------------------------------------------------------------------------
`define VIS_COUNT  24   // blocks (correlators) per prefetch
`define VIS_BSIZE  24   // words per block
`define VIS_WIDTH  32   // visibility word width

// counter widths
`define VIS_CBITS  5    // block index bits
`define VIS_BBITS  5    // word index bits

// pending-bank queue
`define VIS_QDEPTH 15   // max banks waiting
`define VIS_QBITS  4    // bank count bits

`endif
